/* beep_consts.svh */
`ifndef BEEP_CONSTS_SVH
`define BEEP_CONSTS_SVH

`define BEEP_DIGITS  8
`define BEEP_SEQ_MAX 144   // 8 digits x longest pattern

// ------------------------------------------------
// beat length in clocks
`define BEAT_SLOW 64
`define BEAT_MID 32
`define BEAT_FAST 16

// ------------------------------------------------
// tone half-periods in clocks with low pitch first
`define HALF_P0 9
`define HALF_P1 8
`define HALF_P2 7
`define HALF_P3 6
`define HALF_P4 5
`define HALF_P5 4
`define HALF_P6 3
`define HALF_P7 2

// ------------------------------------------------
// digit beat patterns played lsb first where 1 is a tone beat
`define PAT_1 17'b0000_1101_1011_0110_1
`define PAT_2 15'b000_1101_1011_0101
`define PAT_3 15'b0000_1101_1010_101
`define PAT_4 14'b0000_1101_0101_01
`define PAT_5 13'b0000_1010_1010_1
`define PAT_6 14'b0000_1010_1010_11
`define PAT_7 15'b0000_1010_1011_011
`define PAT_8 16'b0000_1010_1101_1011
`define PAT_9 17'b0000_1011_0110_1101_1
`define PAT_A 18'b0000_1101_1011_0110_11

`define LEN_1 8'd17
`define LEN_2 8'd15
`define LEN_3 8'd15
`define LEN_4 8'd14
`define LEN_5 8'd13
`define LEN_6 8'd14
`define LEN_7 8'd15
`define LEN_8 8'd16
`define LEN_9 8'd17
`define LEN_A 8'd18

`endif

/* beep_pkg.sv */
`include "beep_consts.svh"

package beep_pkg;

    typedef logic [3:0]                 digit_t;
    typedef logic [2:0]                 digit_idx_t;
    typedef logic [`BEEP_SEQ_MAX-1:0]   seq_bits_t;
    typedef logic [7:0]                 seq_len_t;
    typedef logic [27:0]                beat_cnt_t;
    typedef logic [17:0]                half_t;

    // key side to encoder
    typedef struct packed {
        logic       start;  // one-cycle pulse
        logic       all;
        digit_idx_t idx;    // used when all is low
    } load_req_t;

    // encoder to sequencer
    typedef struct packed {
        logic      valid;   // one-cycle pulse
        seq_bits_t bits;
        seq_len_t  len;
    } seq_t;

endpackage

/* key_edge.sv */
`timescale 1ns/1ps

module key_edge (
    input  logic                clk,
    input  logic                rst,
    input  logic                enable,
    input  logic                encode_key,
    input  logic [7:0]          digit_key,
    output beep_pkg::load_req_t req
);

    logic                 enc_dly;
    logic [7:0]           dig_dly;
    logic                 enc_edge;
    logic [7:0]           dig_edge;
    beep_pkg::digit_idx_t sel_idx;

    assign enc_edge = encode_key & ~enc_dly;
    assign dig_edge = digit_key & ~dig_dly;

    // lowest pressed index wins
    always_comb begin
        sel_idx = '0;
        for (int i = 7; i >= 0; i--) begin
            if (dig_edge[i])
                sel_idx = beep_pkg::digit_idx_t'(i);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            enc_dly <= 1'b0;
            dig_dly <= '0;
            req     <= '0;
        end else if (!enable) begin
            enc_dly <= 1'b0;
            dig_dly <= '0;
            req     <= '0;
        end else begin
            enc_dly   <= encode_key;
            dig_dly   <= digit_key;
            req.start <= enc_edge | (|dig_edge);
            req.all   <= enc_edge;              // encode beats any digit key
            req.idx   <= enc_edge ? '0 : sel_idx;
        end
    end

endmodule

/* digit_encoder.sv */
`timescale 1ns/1ps
`include "beep_consts.svh"

module digit_encoder (
    input  logic                clk,
    input  logic                rst,
    input  logic                enable,
    input  beep_pkg::load_req_t req,
    input  logic [31:0]         shown,
    output beep_pkg::seq_t      seq
);

    localparam int PAT_W = 18;  // longest digit pattern

    logic                 walking;
    beep_pkg::digit_idx_t pos;
    beep_pkg::digit_idx_t cur_idx;
    beep_pkg::digit_t     digit;
    beep_pkg::seq_bits_t  acc_bits;
    beep_pkg::seq_len_t   acc_len;
    beep_pkg::seq_bits_t  base_bits;
    beep_pkg::seq_len_t   base_len;
    beep_pkg::seq_bits_t  next_bits;
    beep_pkg::seq_len_t   next_len;
    logic [PAT_W-1:0]     pat;
    beep_pkg::seq_len_t   plen;

    // start cycle looks up the first digit itself
    assign cur_idx = req.start ? (req.all ? '0 : req.idx) : pos;
    assign digit   = shown[{cur_idx, 2'b00} +: 4];

    always_comb begin
        case (digit)
            4'h1: begin pat = PAT_W'(`PAT_1); plen = `LEN_1; end
            4'h2: begin pat = PAT_W'(`PAT_2); plen = `LEN_2; end
            4'h3: begin pat = PAT_W'(`PAT_3); plen = `LEN_3; end
            4'h4: begin pat = PAT_W'(`PAT_4); plen = `LEN_4; end
            4'h5: begin pat = PAT_W'(`PAT_5); plen = `LEN_5; end
            4'h6: begin pat = PAT_W'(`PAT_6); plen = `LEN_6; end
            4'h7: begin pat = PAT_W'(`PAT_7); plen = `LEN_7; end
            4'h8: begin pat = PAT_W'(`PAT_8); plen = `LEN_8; end
            4'h9: begin pat = PAT_W'(`PAT_9); plen = `LEN_9; end
            4'ha: begin pat = PAT_W'(`PAT_A); plen = `LEN_A; end
            default: begin
                pat  = '0;    // 0 and b..f stay silent
                plen = '0;
            end
        endcase
    end

    // new pattern lands above the beats gathered so far
    assign base_bits = req.start ? '0 : acc_bits;
    assign base_len  = req.start ? '0 : acc_len;
    assign next_bits = base_bits | (beep_pkg::seq_bits_t'(pat) << base_len);
    assign next_len  = base_len + plen;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            walking  <= 1'b0;
            pos      <= '0;
            acc_bits <= '0;
            acc_len  <= '0;
            seq      <= '0;
        end else if (!enable) begin
            walking  <= 1'b0;
            pos      <= '0;
            acc_bits <= '0;
            acc_len  <= '0;
            seq      <= '0;
        end else begin
            seq.valid <= 1'b0;
            if (req.start && req.all) begin
                walking  <= 1'b1;     // restarts any walk in progress
                pos      <= beep_pkg::digit_idx_t'(1);
                acc_bits <= next_bits;
                acc_len  <= next_len;
            end else if (req.start) begin
                walking   <= 1'b0;
                seq.valid <= 1'b1;
                seq.bits  <= next_bits;
                seq.len   <= next_len;
            end else if (walking) begin
                acc_bits <= next_bits;
                acc_len  <= next_len;
                pos      <= pos + 1'b1;
                if (pos == beep_pkg::digit_idx_t'(`BEEP_DIGITS - 1)) begin
                    walking   <= 1'b0;
                    seq.valid <= 1'b1;
                    seq.bits  <= next_bits;
                    seq.len   <= next_len;
                end
            end
        end
    end

endmodule

/* beat_sequencer.sv */
`timescale 1ns/1ps
`include "beep_consts.svh"

module beat_sequencer (
    input  logic           clk,
    input  logic           rst,
    input  logic           enable,
    input  beep_pkg::seq_t seq,
    input  logic [2:0]     speed_choose,
    output logic           tone_on,
    output logic           playing
);

    beep_pkg::seq_bits_t bits_q;
    beep_pkg::seq_len_t  len_q;
    beep_pkg::seq_len_t  idx;
    beep_pkg::beat_cnt_t beat_len;
    beep_pkg::beat_cnt_t beat_sel;
    beep_pkg::beat_cnt_t cnt;

    always_comb begin
        case (speed_choose)
            3'b100:  beat_sel = beep_pkg::beat_cnt_t'(`BEAT_SLOW);
            3'b010:  beat_sel = beep_pkg::beat_cnt_t'(`BEAT_MID);
            3'b001:  beat_sel = beep_pkg::beat_cnt_t'(`BEAT_FAST);
            default: beat_sel = beep_pkg::beat_cnt_t'(`BEAT_SLOW);
        endcase
    end

    assign playing = idx < len_q;
    assign tone_on = playing && bits_q[idx];

    // ------------------------------------------------
    // beat counter and index
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bits_q   <= '0;
            len_q    <= '0;
            idx      <= '0;
            beat_len <= '0;
            cnt      <= '0;
        end else if (!enable) begin
            bits_q   <= '0;
            len_q    <= '0;
            idx      <= '0;
            beat_len <= '0;
            cnt      <= '0;
        end else if (seq.valid) begin
            bits_q   <= seq.bits;   // new sequence aborts the old one
            len_q    <= seq.len;
            beat_len <= beat_sel;   // speed fixed for the whole run
            idx      <= '0;
            cnt      <= '0;
        end else if (playing) begin
            if (cnt == beat_len - 1'b1) begin
                cnt <= '0;
                idx <= idx + 1'b1;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

/* tone_gen.sv */
`timescale 1ns/1ps
`include "beep_consts.svh"

module tone_gen (
    input  logic       clk,
    input  logic       rst,
    input  logic       enable,
    input  logic       tone_on,
    input  logic [7:0] freq_choose,
    output logic       beep
);

    beep_pkg::half_t half;
    beep_pkg::half_t phase;

    always_comb begin
        case (freq_choose)
            8'b0000_0001: half = beep_pkg::half_t'(`HALF_P0);
            8'b0000_0010: half = beep_pkg::half_t'(`HALF_P1);
            8'b0000_0100: half = beep_pkg::half_t'(`HALF_P2);
            8'b0000_1000: half = beep_pkg::half_t'(`HALF_P3);
            8'b0001_0000: half = beep_pkg::half_t'(`HALF_P4);
            8'b0010_0000: half = beep_pkg::half_t'(`HALF_P5);
            8'b0100_0000: half = beep_pkg::half_t'(`HALF_P6);
            8'b1000_0000: half = beep_pkg::half_t'(`HALF_P7);
            default:      half = '0;   // no pitch gives silence
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= '0;
            beep  <= 1'b0;
        end else if (!enable) begin
            phase <= '0;
            beep  <= 1'b0;
        end else if (tone_on && half != '0) begin
            if (phase == half - 1'b1) begin
                phase <= '0;
                beep  <= ~beep;
            end else begin
                phase <= phase + 1'b1;
            end
        end else begin
            phase <= '0;    // rest beat restarts the phase
            beep  <= 1'b0;
        end
    end

endmodule

/* beep_top.sv */
`timescale 1ns/1ps

module beep_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        enable,
    input  logic [31:0] shown,
    input  logic        encode_key,
    input  logic [7:0]  digit_key,
    input  logic [7:0]  freq_choose,
    input  logic [2:0]  speed_choose,
    output logic        beep,
    output logic        playing
);

    beep_pkg::load_req_t req;
    beep_pkg::seq_t      seq;
    logic                tone_on;

    // ------------------------------------------------
    // keys to load request
    key_edge key_edge_i (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .encode_key (encode_key),
        .digit_key  (digit_key),
        .req        (req)
    );

    // ------------------------------------------------
    // digits to beat sequence, then playback
    digit_encoder digit_encoder_i (
        .clk    (clk),
        .rst    (rst),
        .enable (enable),
        .req    (req),
        .shown  (shown),
        .seq    (seq)
    );

    beat_sequencer beat_sequencer_i (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable),
        .seq          (seq),
        .speed_choose (speed_choose),
        .tone_on      (tone_on),
        .playing      (playing)
    );

    // ------------------------------------------------
    // square wave out
    tone_gen tone_gen_i (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .tone_on     (tone_on),
        .freq_choose (freq_choose),
        .beep        (beep)
    );

endmodule

/* tb_beep.sv */
`timescale 1ns/1ps
`include "beep_consts.svh"

module tb_beep;

    localparam int WAIT_START = 40;                 // cycles until playing rises
    localparam int WAIT_PLAY  = 150 * `BEAT_SLOW;   // longest playback bound

    logic        clk;
    logic        rst;
    logic        enable;
    logic [31:0] shown;
    logic        encode_key;
    logic [7:0]  digit_key;
    logic [7:0]  freq_choose;
    logic [2:0]  speed_choose;
    logic        beep;
    logic        playing;
    logic [31:0] rng_state;

    beep_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable),
        .shown        (shown),
        .encode_key   (encode_key),
        .digit_key    (digit_key),
        .freq_choose  (freq_choose),
        .speed_choose (speed_choose),
        .beep         (beep),
        .playing      (playing)
    );

    always #50 clk = ~clk;

    // ------------------------------------------------
    // helpers
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int beat_cycles(input logic [2:0] speed);
        int n;
        case (speed)
            3'b010:  n = `BEAT_MID;
            3'b001:  n = `BEAT_FAST;
            default: n = `BEAT_SLOW;   // 100 and every invalid code
        endcase
        return n;
    endfunction

    // beat k is character k and 1 marks a tone
    function automatic logic [159:0] beats_from_text(input string text);
        logic [159:0] v;
        v = '0;
        if (text != "-") begin
            for (int k = 0; k < text.len(); k++)
                v[k] = (text[k] == "1");
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [159:0] exp,
                               input logic [159:0] act);
        if (exp !== act) begin
            $display("FAILED %s expected %0h actual %0h", name, exp, act);
            $display("Verification failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic report_stall(input string what);
        $display("timeout: %s", what);
        $display("Verification failed");
        $fatal(1, "simulation stalled");
    endtask

    task automatic press_key(input logic whole, input int idx);
        @(posedge clk);
        if (whole)
            encode_key <= 1'b1;
        else
            digit_key <= 8'b0000_0001 << idx;
        repeat (3) @(posedge clk);  // held 3 cycles
        encode_key <= 1'b0;
        digit_key  <= '0;
    endtask

    task automatic wait_playing(input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (!playing) begin
            if (n == WAIT_START)
                report_stall({name, ": playing never went high after the key press"});
            n++;
            @(negedge clk);
        end
    endtask

    task automatic wait_beep_high(input string name);
        int n;
        n = 0;
        while (!beep) begin
            if (n == WAIT_PLAY)
                report_stall({name, ": beep never went high during playback"});
            n++;
            @(negedge clk);
        end
    endtask

    // sample 0 is the negedge where playing was first seen high
    task automatic measure_play(input string name, input int beat, output int dur,
                                output logic [159:0] beats);
        int n;
        n     = 0;
        beats = '0;
        while (playing) begin
            if (n == WAIT_PLAY)
                report_stall({name, ": playing stayed high too long"});
            if (n > 0 && beep)
                beats[(n - 1) / beat] = 1'b1;
            n++;
            @(negedge clk);
        end
        // beep trails tone_on by one cycle so this sample belongs to the last beat
        if (n > 0 && beep)
            beats[(n - 1) / beat] = 1'b1;
        dur = n;
    endtask

    task automatic check_quiet(input string name);
        repeat (WAIT_START) begin
            @(negedge clk);
            check_value({name, " quiet"}, '0, {beep, playing});
        end
    endtask

    // ------------------------------------------------
    // one golden line
    task automatic run_test(input string name, input logic [31:0] shown_v,
                            input string mode, input logic [2:0] speed_v,
                            input logic [7:0] freq_v, input int len_v, input string text);
        int           beat;
        int           dur;
        logic [159:0] exp_beats;
        logic [159:0] got_beats;

        beat      = beat_cycles(speed_v);
        exp_beats = beats_from_text(text);
        if ($countones(freq_v) != 1)
            exp_beats = '0;     // silent without a one-hot pitch

        @(posedge clk);
        shown        <= (mode == "restart") ? 32'h9999_9999 : shown_v;
        speed_choose <= speed_v;
        freq_choose  <= freq_v;

        if (mode == "enable") begin
            press_key(1'b1, 0);
            wait_playing(name);
            wait_beep_high(name);
            @(posedge clk);
            enable <= 1'b0;
            @(posedge clk);
            @(negedge clk);
            check_value({name, " enable drop"}, '0, {beep, playing});
            @(posedge clk);
            enable <= 1'b1;
            check_quiet(name);  // cleared sequence must not resume
        end else begin
            if (mode == "restart") begin
                press_key(1'b1, 0);
                wait_playing(name);
                repeat (2 * beat) @(posedge clk);
                shown <= shown_v;
                press_key(1'b1, 0);
                repeat (7) @(posedge clk); // new playing 10 cycles after key drive
            end else begin
                press_key(mode == "all", mode[0] - "0");
            end
            if (len_v == 0) begin
                check_quiet(name);
            end else begin
                wait_playing(name);
                measure_play(name, beat, dur, got_beats);
                check_value({name, " duration"}, len_v * beat, dur);
                check_value({name, " beats"}, exp_beats, got_beats);
            end
        end
    endtask

    // ------------------------------------------------
    // main sequence
    initial begin
        int               fd;
        int               cnt;
        int               ntests;
        int               gap;
        int               len_v;
        string            name;
        string            mode;
        string            text;
        logic [31:0]      shown_v;
        logic [2:0]       speed_v;
        logic [7:0]       freq_v;
        logic [8*128-1:0] skip;

        clk          = 1'b0;
        rst          = 1'b1;
        enable       = 1'b1;
        shown        = '0;
        encode_key   = 1'b0;
        digit_key    = '0;
        freq_choose  = '0;
        speed_choose = 3'b100;
        rng_state    = 32'hd4a6_3c15;
        ntests       = 0;

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("beep_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open beep_golden.txt");
            $display("Verification failed");
            $fatal(1, "golden file missing");
        end

        while (!$feof(fd)) begin
            cnt = $fscanf(fd, "%s", name);
            if (cnt != 1)
                break;
            if (name[0] == "#") begin
                cnt = $fgets(skip, fd);     // column notes
            end else begin
                cnt = $fscanf(fd, "%h %s %h %h %d %s",
                              shown_v, mode, speed_v, freq_v, len_v, text);
                if (cnt != 6) begin
                    $display("golden line for %s is incomplete", name);
                    $display("Verification failed");
                    $fatal(1, "bad golden line");
                end
                run_test(name, shown_v, mode, speed_v, freq_v, len_v, text);
                ntests++;
                rng_state = xorshift(rng_state);
                gap       = 2 + rng_state % 19;
                repeat (gap) @(posedge clk);
            end
        end
        $fclose(fd);

        if (ntests == 0) begin
            $display("no test lines found in beep_golden.txt");
            $display("Verification failed");
            $fatal(1, "empty golden file");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

/* beep_golden.txt */
# name shown mode speed freq len beats
# mode is all, a digit index, restart or enable; beats lsb first, 1 tone, 0 rest, - none
all_mix_a   0b0a0305 all     1 80 46 1010101010000101010110110000110110110110110000
all_mix_b   1c0700f2 all     2 04 47 10101101101100011011010101000010110110110110000
all_mix_c   80e00906 all     4 01 47 11010101010000110110110110100001101101101010000
speed_bad   00000040 all     6 10 14 10101010110000
key0        8a976f21 0       1 01 17 10110110110110000
key1        8a976f21 1       2 02 15 101011011011000
key2_blank  8a976f21 2       4 04 0  -
key3        8a976f21 3       0 08 14 11010101010000
key4        8a976f21 4       4 40 15 110110101010000
key5        8a976f21 5       1 80 17 11011011011010000
key6        8a976f21 6       2 20 18 110110110110110000
key7        8a976f21 7       7 10 16 1101101101010000
key0_blank  0b04c530 0       1 02 0  -
silent_all  00000091 all     1 00 34 1011011011011000011011011011010000
silent_key  00000300 2       2 03 15 101010110110000
restart     00000a05 restart 1 20 31 1010101010000110110110110110000
enable_drop 00000007 enable  1 08 15 -

/* build.f */
+incdir+.
beep_pkg.sv
key_edge.sv
digit_encoder.sv
beat_sequencer.sv
tone_gen.sv
beep_top.sv
tb_beep.sv
